// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f)

.PHONY: all run clean

all: run

obj_dir/Vkinpira_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module kinpira_tb -f project.f

run: obj_dir/Vkinpira_tb
	@out="$$(./obj_dir/Vkinpira_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// ==== logic/gobou_core.sv ====
module gobou_core import kinpira_pkg::*; (
  input  logic       clk,
  input  logic       xrst,
  layer_if.engine    layer,
  buf_port_if.master img,
  buf_port_if.master net
);

  gobou_state_t state;

  logic [LWIDTH-1:0]  cnt_o;
  logic [LWIDTH-1:0]  cnt_i;
  logic [NETSIZE-1:0] row_base;
  logic               pend;
  logic               last_in;
  logic               last_out;

  logic signed [2*DWIDTH-1:0] prod;
  logic signed [ACC_WIDTH-1:0] prod_ext;
  logic signed [ACC_WIDTH-1:0] bias_ext;
  logic signed [ACC_WIDTH-1:0] acc;
  logic signed [ACC_WIDTH-1:0] scaled;
  logic [DWIDTH-1:0]           result;

  assign last_in  = cnt_i == layer.total_in;
  assign last_out = cnt_o == layer.total_out - LWIDTH'(1);

  // Product of the pair issued last cycle
  assign prod     = $signed(img.rdata) * $signed(net.rdata);
  assign prod_ext = {{(ACC_WIDTH-2*DWIDTH){prod[2*DWIDTH-1]}}, prod};

  // Bias aligned to the product fraction
  assign bias_ext = {{(ACC_WIDTH-DWIDTH-FRAC_BITS){net.rdata[DWIDTH-1]}},
                     net.rdata, {FRAC_BITS{1'b0}}};

  assign scaled = acc >>> FRAC_BITS;

  // ReLU then saturate
  always_comb begin
    if (scaled[ACC_WIDTH-1])
      result = '0;
    else if (|scaled[ACC_WIDTH-2:DWIDTH-1])
      result = DMAX;
    else
      result = scaled[DWIDTH-1:0];
  end

  // Row o of the weights holds total_in weights then the bias
  assign net.addr  = row_base + NETSIZE'(cnt_i);
  assign net.we    = 1'b0;
  assign net.wdata = '0;

  always_comb begin
    if (state == S_WRITE)
      img.addr = layer.out_offset + IMGSIZE'(cnt_o);
    else
      img.addr = layer.in_offset + IMGSIZE'(cnt_i);
  end

  assign img.we     = state == S_WRITE;
  assign img.wdata  = result;
  assign layer.done = state == S_DONE;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= S_IDLE;
      cnt_o    <= '0;
      cnt_i    <= '0;
      row_base <= '0;
      pend     <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (layer.req) begin
            cnt_o    <= '0;
            row_base <= layer.net_offset;
            state    <= (layer.total_out == '0) ? S_DONE : S_FETCH;
          end
        end
        S_FETCH: begin
          cnt_i <= '0;
          pend  <= 1'b0;
          state <= S_ACC;
        end
        S_ACC: begin
          // Last issue fetches the bias, no product follows it
          pend <= !last_in;
          if (last_in)
            state <= S_BIAS;
          else
            cnt_i <= cnt_i + 1'b1;
        end
        S_BIAS: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          if (last_out) begin
            state <= S_DONE;
          end else begin
            cnt_o    <= cnt_o + 1'b1;
            row_base <= row_base + NETSIZE'(layer.total_in) + NETSIZE'(1);
            state    <= S_FETCH;
          end
        end
        S_DONE: begin
          if (!layer.req)
            state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      S_FETCH: acc <= '0;
      S_ACC:   if (pend) acc <= acc + prod_ext;
      S_BIAS:  acc <= acc + bias_ext;
      default: ;
    endcase
  end

endmodule

// ==== logic/kinpira_if.sv ====
// Single access port of a buffer, read data one cycle after addr
interface buf_port_if import kinpira_pkg::*; #(
  parameter int AW = IMGSIZE
) ();
  logic              we;
  logic [AW-1:0]     addr;
  logic [DWIDTH-1:0] wdata;
  logic [DWIDTH-1:0] rdata;

  modport master (output we, output addr, output wdata, input rdata);
  modport ram (input we, input addr, input wdata, output rdata);
endinterface

// Layer parameters and handshake between register file and engine
interface layer_if import kinpira_pkg::*; ();
  logic               req;
  logic [IMGSIZE-1:0] in_offset;
  logic [IMGSIZE-1:0] out_offset;
  logic [NETSIZE-1:0] net_offset;
  logic [LWIDTH-1:0]  total_out;
  logic [LWIDTH-1:0]  total_in;
  logic               done;

  modport regs (
    output req, output in_offset, output out_offset, output net_offset,
    output total_out, output total_in,
    input  done
  );
  modport engine (
    input  req, input in_offset, input out_offset, input net_offset,
    input  total_out, input total_in,
    output done
  );
endinterface

// ==== logic/kinpira_pkg.sv ====
package kinpira_pkg;

  // Data and bus widths
  localparam int DWIDTH     = 16;
  localparam int BWIDTH     = 32;
  localparam int ACC_WIDTH  = 40;
  localparam int ADDR_WIDTH = 12;

  // Memory and layer count widths
  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 10;
  localparam int LWIDTH  = 10;

  // Q8 fixed point, results clamp to the largest positive word
  localparam int FRAC_BITS = 8;
  localparam logic [DWIDTH-1:0] DMAX = {1'b0, {(DWIDTH-1){1'b1}}};

  typedef enum logic {
    OWNER_HOST  = 1'b0,
    OWNER_GOBOU = 1'b1
  } owner_t;

  // Top two bits of the word address
  typedef enum logic [1:0] {
    REGION_REGS = 2'd0,
    REGION_IMG  = 2'd1,
    REGION_NET  = 2'd2
  } region_t;

  typedef enum logic [2:0] {
    REG_WHICH      = 3'd0,
    REG_REQ        = 3'd1,
    REG_IN_OFFSET  = 3'd2,
    REG_OUT_OFFSET = 3'd3,
    REG_NET_OFFSET = 3'd4,
    REG_TOTAL_OUT  = 3'd5,
    REG_TOTAL_IN   = 3'd6,
    REG_STATUS     = 3'd7
  } reg_t;

  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_FETCH = 3'd1,
    S_ACC   = 3'd2,
    S_BIAS  = 3'd3,
    S_WRITE = 3'd4,
    S_DONE  = 3'd5
  } gobou_state_t;

endpackage

// ==== logic/kinpira_top.sv ====
module kinpira_top import kinpira_pkg::*; (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] adr,
  input  logic [BWIDTH-1:0]     wdata,
  output logic [BWIDTH-1:0]     rdata,
  output logic                  ack
);

  logic              reg_we;
  reg_t              reg_sel;
  logic [BWIDTH-1:0] reg_rdata;
  owner_t            owner;

  // Host and engine side of each buffer
  buf_port_if #(.AW(IMGSIZE)) host_img ();
  buf_port_if #(.AW(NETSIZE)) host_net ();
  buf_port_if #(.AW(IMGSIZE)) gobou_img ();
  buf_port_if #(.AW(NETSIZE)) gobou_net ();

  layer_if layer ();

  ninjin_host_port i_host_port (
    .clk       (clk),
    .xrst      (xrst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .wdata     (wdata),
    .rdata     (rdata),
    .ack       (ack),
    .reg_we    (reg_we),
    .reg_sel   (reg_sel),
    .reg_rdata (reg_rdata),
    .img       (host_img),
    .net       (host_net)
  );

  ninjin_param_regs i_param_regs (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_sel   (reg_sel),
    .reg_wdata (wdata),
    .reg_rdata (reg_rdata),
    .owner     (owner),
    .layer     (layer)
  );

  gobou_core i_gobou (
    .clk   (clk),
    .xrst  (xrst),
    .layer (layer),
    .img   (gobou_img),
    .net   (gobou_net)
  );

  ninjin_buf #(.AW(IMGSIZE)) i_img_buf (
    .clk    (clk),
    .owner  (owner),
    .host   (host_img),
    .engine (gobou_img)
  );

  ninjin_buf #(.AW(NETSIZE)) i_net_buf (
    .clk    (clk),
    .owner  (owner),
    .host   (host_net),
    .engine (gobou_net)
  );

endmodule

// ==== logic/ninjin_buf.sv ====
module ninjin_buf import kinpira_pkg::*; #(
  parameter int AW = IMGSIZE
) (
  input  logic   clk,
  input  owner_t owner,
  buf_port_if.ram host,
  buf_port_if.ram engine
);

  logic [DWIDTH-1:0] mem [2**AW];
  logic              we;
  logic [AW-1:0]     addr;
  logic [DWIDTH-1:0] wdata;
  logic [DWIDTH-1:0] rdata;

  // Owner picks the side that drives the single port
  always_comb begin
    if (owner == OWNER_HOST) begin
      we    = host.we;
      addr  = host.addr;
      wdata = host.wdata;
    end else begin
      we    = engine.we;
      addr  = engine.addr;
      wdata = engine.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // Both sides see the same read data
  assign host.rdata   = rdata;
  assign engine.rdata = rdata;

endmodule

// ==== logic/ninjin_host_port.sv ====
module ninjin_host_port import kinpira_pkg::*; (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] adr,
  input  logic [BWIDTH-1:0]     wdata,
  output logic [BWIDTH-1:0]     rdata,
  output logic                  ack,
  output logic                  reg_we,
  output reg_t                  reg_sel,
  input  logic [BWIDTH-1:0]     reg_rdata,
  buf_port_if.master            img,
  buf_port_if.master            net
);

  region_t region;
  logic    start;
  logic    wr_start;

  assign region = region_t'(adr[ADDR_WIDTH-1:ADDR_WIDTH-2]);

  // First cycle of a cycle, ack not yet given
  assign start    = cyc && stb && !ack;
  assign wr_start = start && we;

  assign reg_sel = reg_t'(adr[2:0]);
  assign reg_we  = wr_start && (region == REGION_REGS);

  assign img.we    = wr_start && (region == REGION_IMG);
  assign img.addr  = adr[IMGSIZE-1:0];
  assign img.wdata = wdata[DWIDTH-1:0];

  assign net.we    = wr_start && (region == REGION_NET);
  assign net.addr  = adr[NETSIZE-1:0];
  assign net.wdata = wdata[DWIDTH-1:0];

  // Ack on the cycle after the strobe is seen, one clock wide
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack <= 1'b0;
    end else begin
      ack <= start;
    end
  end

  // Address is held through ack, so the region still picks the source
  always_comb begin
    case (region)
      REGION_REGS:
        rdata = reg_rdata;
      REGION_IMG:
        rdata = {{(BWIDTH-DWIDTH){img.rdata[DWIDTH-1]}}, img.rdata};
      REGION_NET:
        rdata = {{(BWIDTH-DWIDTH){net.rdata[DWIDTH-1]}}, net.rdata};
      default:
        rdata = '0;
    endcase
  end

endmodule

// ==== logic/ninjin_param_regs.sv ====
module ninjin_param_regs import kinpira_pkg::*; (
  input  logic              clk,
  input  logic              xrst,
  input  logic              reg_we,
  input  reg_t              reg_sel,
  input  logic [BWIDTH-1:0] reg_wdata,
  output logic [BWIDTH-1:0] reg_rdata,
  output owner_t            owner,
  layer_if.regs             layer
);

  logic               req;
  logic [IMGSIZE-1:0] in_offset;
  logic [IMGSIZE-1:0] out_offset;
  logic [NETSIZE-1:0] net_offset;
  logic [LWIDTH-1:0]  total_out;
  logic [LWIDTH-1:0]  total_in;
  owner_t             owner_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      owner      <= OWNER_HOST;
      owner_q    <= OWNER_HOST;
      req        <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else begin
      owner_q <= owner;
      if (reg_we) begin
        case (reg_sel)
          REG_WHICH:      owner      <= owner_t'(reg_wdata[0]);
          REG_REQ:        req        <= reg_wdata[0];
          REG_IN_OFFSET:  in_offset  <= reg_wdata[IMGSIZE-1:0];
          REG_OUT_OFFSET: out_offset <= reg_wdata[IMGSIZE-1:0];
          REG_NET_OFFSET: net_offset <= reg_wdata[NETSIZE-1:0];
          REG_TOTAL_OUT:  total_out  <= reg_wdata[LWIDTH-1:0];
          REG_TOTAL_IN:   total_in   <= reg_wdata[LWIDTH-1:0];
          default:        ;
        endcase
      end
    end
  end

  // Engine only starts while it owns the buffers
  assign layer.req        = req && (owner == OWNER_GOBOU);
  assign layer.in_offset  = in_offset;
  assign layer.out_offset = out_offset;
  assign layer.net_offset = net_offset;
  assign layer.total_out  = total_out;
  assign layer.total_in   = total_in;

  always_comb begin
    reg_rdata = '0;
    case (reg_sel)
      REG_WHICH:      reg_rdata[0] = owner;
      REG_REQ:        reg_rdata[0] = req;
      REG_IN_OFFSET:  reg_rdata[IMGSIZE-1:0] = in_offset;
      REG_OUT_OFFSET: reg_rdata[IMGSIZE-1:0] = out_offset;
      REG_NET_OFFSET: reg_rdata[NETSIZE-1:0] = net_offset;
      REG_TOTAL_OUT:  reg_rdata[LWIDTH-1:0] = total_out;
      REG_TOTAL_IN:   reg_rdata[LWIDTH-1:0] = total_in;
      REG_STATUS:     reg_rdata[1:0] = {owner_q, layer.done};
      default:        ;
    endcase
  end

endmodule

// ==== project.f ====
logic/kinpira_pkg.sv
logic/kinpira_if.sv
logic/ninjin_host_port.sv
logic/ninjin_param_regs.sv
logic/ninjin_buf.sv
logic/gobou_core.sv
logic/kinpira_top.sv
tb/kinpira_tb.sv

// ==== tb/kinpira_tb.sv ====
module kinpira_tb import kinpira_pkg::*; ();

  localparam int TOTAL_IN   = 8;
  localparam int TOTAL_OUT  = 6;
  localparam int IN_OFFSET  = 16;
  localparam int OUT_OFFSET = 64;
  localparam int NET_OFFSET = 100;
  localparam int ROUNDS     = 3;
  localparam int BUF_WORDS  = 16;
  // Fetch, total_in+1 issues, bias and write for each output
  localparam int LAYER_CYCLES = TOTAL_OUT * (TOTAL_IN + 4);
  localparam int WB_OPS = 8 + 10 * ROUNDS + 9 + 4 * BUF_WORDS + TOTAL_IN
                        + TOTAL_OUT * (TOTAL_IN + 1) + 2 * TOTAL_OUT + TOTAL_IN
                        + LAYER_CYCLES / 3 + 16;
  // Three clocks per bus cycle, two layer-length polls, margin of two
  localparam int CYCLE_LIMIT = (3 * WB_OPS + 2 * LAYER_CYCLES + 8) * 2;

  logic                  clk;
  logic                  xrst;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [ADDR_WIDTH-1:0] adr;
  logic [BWIDTH-1:0]     wdata;
  logic [BWIDTH-1:0]     rdata;
  logic                  ack;

  integer  seed = 32'hbc4e2a31;
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  shortint in_vals [TOTAL_IN];
  shortint w_vals [TOTAL_OUT][TOTAL_IN+1];

  kinpira_top i_dut (
    .clk   (clk),
    .xrst  (xrst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .wdata (wdata),
    .rdata (rdata),
    .ack   (ack)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  // Wishbone ack timing
  ack_in_cycle: assert property (@(posedge clk) disable iff (!xrst) ack |-> cyc && stb)
    else begin
      errors++;
      $display("ack raised at %0t outside an open bus cycle", $time);
    end
  ack_pulse: assert property (@(posedge clk) disable iff (!xrst) ack |=> !ack)
    else begin
      errors++;
      $display("ack held longer than one clock at %0t", $time);
    end
  ack_follows_stb: assert property (@(posedge clk) disable iff (!xrst) $rose(stb) |=> ack)
    else begin
      errors++;
      $display("ack missing one clock after stb rose, at %0t", $time);
    end

  function automatic logic [ADDR_WIDTH-1:0] reg_adr(reg_t r);
    return {REGION_REGS, {(ADDR_WIDTH-5){1'b0}}, r};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] buf_adr(region_t rg, int a);
    return {rg, IMGSIZE'(a)};
  endfunction

  function automatic logic [BWIDTH-1:0] reg_mask(reg_t r);
    case (r)
      REG_IN_OFFSET, REG_OUT_OFFSET: return (32'd1 << IMGSIZE) - 32'd1;
      REG_NET_OFFSET:                return (32'd1 << NETSIZE) - 32'd1;
      REG_TOTAL_OUT, REG_TOTAL_IN:   return (32'd1 << LWIDTH) - 32'd1;
      default:                       return 32'd1;
    endcase
  endfunction

  // Dot product plus Q8 bias, scaled back, ReLU and clamp to 0x7fff
  function automatic logic [DWIDTH-1:0] dense_ref(int o);
    longint acc;
    longint scaled;
    int     i;
    acc = longint'(w_vals[o][TOTAL_IN]) * (longint'(1) << FRAC_BITS);
    for (i = 0; i < TOTAL_IN; i++)
      acc += longint'(in_vals[i]) * longint'(w_vals[o][i]);
    scaled = acc >>> FRAC_BITS;
    if (scaled < 0)
      return '0;
    else if (scaled > 32767)
      return 16'h7fff;
    return scaled[DWIDTH-1:0];
  endfunction

  task automatic check_value(input string name, input logic [BWIDTH-1:0] got,
                             input logic [BWIDTH-1:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      end
  endtask

  task automatic bus_cycle(input logic write, input logic [ADDR_WIDTH-1:0] a,
                           input logic [BWIDTH-1:0] d, output logic [BWIDTH-1:0] q);
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    wdata = d;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    q = rdata;
    // Cycle closes at the edge that samples ack
    @(posedge clk);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input logic [ADDR_WIDTH-1:0] a, input logic [BWIDTH-1:0] d);
    logic [BWIDTH-1:0] q;
    bus_cycle(1'b1, a, d, q);
  endtask

  task automatic wb_read(input logic [ADDR_WIDTH-1:0] a, output logic [BWIDTH-1:0] q);
    bus_cycle(1'b0, a, '0, q);
  endtask

  task automatic read_check(input logic [ADDR_WIDTH-1:0] a, input string name,
                            input logic [BWIDTH-1:0] exp);
    logic [BWIDTH-1:0] q;
    wb_read(a, q);
    check_value(name, q, exp);
  endtask

  task automatic load_layer();
    int i;
    int o;
    for (i = 0; i < TOTAL_IN; i++) begin
      in_vals[i] = shortint'($random(seed) % 1024);
      wb_write(buf_adr(REGION_IMG, IN_OFFSET + i), 32'(in_vals[i]));
    end
    for (o = 0; o < TOTAL_OUT; o++) begin
      for (i = 0; i <= TOTAL_IN; i++) begin
        // Row 0 saturates, row 1 ends negative
        if (o == 0)
          w_vals[o][i] = (i == TOTAL_IN) ? 16'sh7fff : in_vals[i];
        else if (o == 1)
          w_vals[o][i] = (i == TOTAL_IN) ? shortint'(16'h8000) : shortint'(-in_vals[i]);
        else
          w_vals[o][i] = shortint'($random(seed) % 1024);
        wb_write(buf_adr(REGION_NET, NET_OFFSET + o * (TOTAL_IN + 1) + i),
                 32'(w_vals[o][i]));
      end
    end
  endtask

  task automatic check_outputs();
    int o;
    for (o = 0; o < TOTAL_OUT; o++)
      read_check(buf_adr(REGION_IMG, OUT_OFFSET + o), $sformatf("out[%0d]", o),
                 {16'h0, dense_ref(o)});
  endtask

  initial begin
    logic [BWIDTH-1:0] q;
    shortint           word;
    int                r;
    int                k;
    clk   = 1'b0;
    xrst  = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    wdata = '0;
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;

    check_value("ack", 32'(ack), 32'd0);
    for (r = 0; r < 8; r++)
      read_check(reg_adr(reg_t'(r[2:0])), $sformatf("reg %0d", r), 32'd0);

    for (k = 0; k < ROUNDS; k++) begin
      for (r = REG_IN_OFFSET; r <= REG_TOTAL_IN; r++) begin
        q = $random(seed);
        wb_write(reg_adr(reg_t'(r[2:0])), q);
        read_check(reg_adr(reg_t'(r[2:0])), $sformatf("reg %0d", r),
                   q & reg_mask(reg_t'(r[2:0])));
      end
    end
    wb_write(reg_adr(REG_REQ), 32'hffff_ffff);
    read_check(reg_adr(REG_REQ), "req", 32'd1);
    wb_write(reg_adr(REG_REQ), 32'd0);
    read_check(reg_adr(REG_REQ), "req", 32'd0);
    wb_write(reg_adr(REG_WHICH), 32'd3);
    read_check(reg_adr(REG_WHICH), "which", 32'd1);
    read_check(reg_adr(REG_STATUS), "status", 32'd2);
    wb_write(reg_adr(REG_WHICH), 32'(OWNER_HOST));
    read_check(reg_adr(REG_WHICH), "which", 32'd0);

    for (k = 0; k < BUF_WORDS; k++) begin
      word = shortint'($random(seed));
      wb_write(buf_adr(REGION_IMG, k * 61), {16'h0, word});
      read_check(buf_adr(REGION_IMG, k * 61), "img", {{16{word[15]}}, word});
      word = shortint'($random(seed));
      wb_write(buf_adr(REGION_NET, k * 53 + 7), {16'h0, word});
      read_check(buf_adr(REGION_NET, k * 53 + 7), "net", {{16{word[15]}}, word});
    end

    load_layer();
    wb_write(reg_adr(REG_IN_OFFSET), IN_OFFSET);
    wb_write(reg_adr(REG_OUT_OFFSET), OUT_OFFSET);
    wb_write(reg_adr(REG_NET_OFFSET), NET_OFFSET);
    wb_write(reg_adr(REG_TOTAL_IN), TOTAL_IN);
    wb_write(reg_adr(REG_TOTAL_OUT), TOTAL_OUT);
    wb_write(reg_adr(REG_WHICH), 32'(OWNER_GOBOU));
    wb_write(reg_adr(REG_REQ), 32'd1);
    do begin
      wb_read(reg_adr(REG_STATUS), q);
    end while (!q[0]);
    check_value("status", q, 32'd3);
    wb_write(reg_adr(REG_REQ), 32'd0);
    read_check(reg_adr(REG_STATUS), "status", 32'd2);
    wb_write(reg_adr(REG_WHICH), 32'(OWNER_HOST));
    check_outputs();

    // Host still owns the buffers, so the engine must stay idle
    wb_write(reg_adr(REG_REQ), 32'd1);
    for (k = 0; k < LAYER_CYCLES / 3 + 4; k++)
      read_check(reg_adr(REG_STATUS), "status", 32'd0);
    for (k = 0; k < TOTAL_IN; k++)
      read_check(buf_adr(REGION_IMG, IN_OFFSET + k), $sformatf("in[%0d]", k),
                 32'(in_vals[k]));
    check_outputs();
    wb_write(reg_adr(REG_REQ), 32'd0);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
